//--- zxKeyPkg.sv
// Shared matrix sizes, key index type and PS/2 set 2 codes; only scan code set 2 is supported
`default_nettype none

package zxKeyPkg;

    // ==============================
    // Matrix geometry
    // ==============================
    localparam int ROWS = 8;                  // Half rows selected by A15..A8
    localparam int COLS = 5;                  // Keys per half row, D0..D4

    // One Spectrum key position in the matrix
    typedef struct packed {
        logic       valid;                    // Clear means no key
        logic [2:0] row;                      // Half row, 0 is CAPS SHIFT..V
        logic [2:0] col;                      // Bit within the row
    } keyIdx;

    localparam keyIdx KEY_NONE = '{valid: 1'b0, row: 3'd0, col: 3'd0};

    // ==============================
    // PS/2 prefix and shift codes
    // ==============================
    localparam logic [7:0] SC_EXTEND  = 8'hE0;   // Extended key follows
    localparam logic [7:0] SC_RELEASE = 8'hF0;   // Break code follows
    localparam logic [7:0] SC_LSHIFT  = 8'h12;   // Left shift, local state only
    localparam logic [7:0] SC_RSHIFT  = 8'h59;   // Right shift, local state only

    // ==============================
    // Modifier keys on the Spectrum side
    // ==============================
    localparam keyIdx CAPS_KEY = '{valid: 1'b1, row: 3'd0, col: 3'd0};  // CAPS SHIFT
    localparam keyIdx SYM_KEY  = '{valid: 1'b1, row: 3'd7, col: 3'd1};  // SYMBOL SHIFT

    // Builds a valid key index from a row and a column
    function automatic keyIdx makeKey(
        input logic [2:0] row,
        input logic [2:0] col
    );
        keyIdx k;
        k.valid = 1'b1;
        k.row   = row;
        k.col   = col;
        return k;
    endfunction

endpackage

`default_nettype wire

//--- ps2Receiver.sv
// PS/2 device-to-host frames only; clk must be many times faster than the PS/2 clock
`timescale 1ns/1ps
`default_nettype none

module ps2Receiver #(
    parameter int FILTER_LEN = 4              // Equal samples needed from 2 to 16
) (
    input  wire logic       clk,
    input  wire logic       nreset,
    input  wire logic       ps2Clk,           // Raw keyboard clock
    input  wire logic       ps2Data,          // Raw keyboard data
    output logic      [7:0] scanCode,         // Valid while a strobe is high
    output logic            scanValid,        // One cycle per good frame
    output logic            scanError         // One cycle per bad frame
);

    localparam int CW = $clog2(FILTER_LEN);

    logic [1:0]    clkSync;                   // Two flop synchronizers
    logic [1:0]    dataSync;
    logic          clkFilt;                   // Debounced PS/2 clock
    logic          clkFiltQ;                  // Previous value for edge detect
    logic [CW-1:0] filtCnt;                   // Run of samples unlike clkFilt
    logic [3:0]    bitCnt;                    // Bits taken in this frame
    logic [11:0]   idleCnt;                   // Cycles with clkFilt high
    logic [9:0]    shiftReg;                  // Start, data and parity shifted LSB first
    logic [10:0]   frame;
    logic          fallEdge;
    logic          frameOk;

    assign fallEdge = clkFiltQ & ~clkFilt;
    assign frame    = {dataSync[1], shiftReg};     // Stop bit is the live sample
    assign frameOk  = !frame[0] && (^frame[9:1]) && frame[10];  // Start, odd parity and stop
    assign scanCode = shiftReg[8:1];

    // ==============================
    // Synchronizer and clock filter
    // ==============================
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            clkSync  <= 2'b11;                // Lines idle high
            dataSync <= 2'b11;
            clkFilt  <= 1'b1;
            clkFiltQ <= 1'b1;
            filtCnt  <= '0;
            idleCnt  <= '0;
        end else begin
            clkSync  <= {clkSync[0], ps2Clk};
            dataSync <= {dataSync[0], ps2Data};
            clkFiltQ <= clkFilt;
            if (clkSync[1] == clkFilt) begin
                filtCnt <= '0;                // Glitch ends the run
            end else if (filtCnt == CW'(FILTER_LEN - 1)) begin
                clkFilt <= clkSync[1];        // Enough equal samples
                filtCnt <= '0;
            end else begin
                filtCnt <= filtCnt + 1'b1;
            end
            if (!clkFilt)
                idleCnt <= '0;
            else if (idleCnt != '1)
                idleCnt <= idleCnt + 1'b1;    // Saturates at 4095
        end
    end

    // ==============================
    // Frame counter and strobes
    // ==============================
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            bitCnt    <= '0;
            scanValid <= 1'b0;
            scanError <= 1'b0;
        end else begin
            scanValid <= 1'b0;
            scanError <= 1'b0;
            if (fallEdge) begin
                if (bitCnt == 4'd10) begin    // Stop bit sampled now
                    bitCnt    <= '0;
                    scanValid <= frameOk;
                    scanError <= !frameOk;
                end else begin
                    bitCnt <= bitCnt + 1'b1;
                end
            end else if (idleCnt == '1) begin
                bitCnt <= '0;                 // Long idle drops a partial frame
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fallEdge && bitCnt != 4'd10)
            shiftReg <= {dataSync[1], shiftReg[9:1]};
    end

    // Device changes data only while the clock is high
    assert property (@(posedge clk) disable iff (!nreset) fallEdge |-> $stable(dataSync[1]));

endmodule

`default_nettype wire

//--- scanDecoder.sv
// Set 2 make/break codes only; right Ctrl and right Alt are not mapped and shift is local state
`timescale 1ns/1ps
`default_nettype none

module scanDecoder
    import zxKeyPkg::*;
(
    input  wire logic       clk,
    input  wire logic       nreset,
    input  wire logic [7:0] scanCode,
    input  wire logic       scanValid,
    input  wire logic       scanError,
    output logic            keyValid,         // One action per cycle
    output keyIdx           keyA,             // Always a valid key with keyValid
    output keyIdx           keyB,             // Second key or KEY_NONE
    output logic            keyUp             // 1 for release and 0 for press
);

    logic        extended;                    // E0 seen
    logic        released;                    // F0 seen
    logic        shifted;                     // Local shift held
    logic        isShift;
    keyIdx [1:0] pair;                        // [1] goes to keyA and [0] to keyB

    assign isShift = !extended && (scanCode == SC_LSHIFT || scanCode == SC_RSHIFT);

    // ==============================
    // Scan code to key mapping
    // ==============================
    always_comb begin
        pair = {KEY_NONE, KEY_NONE};          // Unmapped and shift codes
        if (extended) begin
            case (scanCode)
                8'h6B: pair = {CAPS_KEY, makeKey(3, 4)};   // Left is CAPS + 5
                8'h72: pair = {CAPS_KEY, makeKey(4, 4)};   // Down is CAPS + 6
                8'h75: pair = {CAPS_KEY, makeKey(4, 3)};   // Up is CAPS + 7
                8'h74: pair = {CAPS_KEY, makeKey(4, 2)};   // Right is CAPS + 8
                default: ;
            endcase
        end else begin
            case (scanCode)
                8'h14: pair = {CAPS_KEY, KEY_NONE};        // Ctrl
                8'h1A: pair = {makeKey(0, 1), KEY_NONE};   // Z
                8'h22: pair = {makeKey(0, 2), KEY_NONE};   // X
                8'h21: pair = {makeKey(0, 3), KEY_NONE};   // C
                8'h2A: pair = {makeKey(0, 4), KEY_NONE};   // V
                8'h1C: pair = {makeKey(1, 0), KEY_NONE};   // A
                8'h1B: pair = {makeKey(1, 1), KEY_NONE};   // S
                8'h23: pair = {makeKey(1, 2), KEY_NONE};   // D
                8'h2B: pair = {makeKey(1, 3), KEY_NONE};   // F
                8'h34: pair = {makeKey(1, 4), KEY_NONE};   // G
                8'h15: pair = {makeKey(2, 0), KEY_NONE};   // Q
                8'h1D: pair = {makeKey(2, 1), KEY_NONE};   // W
                8'h24: pair = {makeKey(2, 2), KEY_NONE};   // E
                8'h2D: pair = {makeKey(2, 3), KEY_NONE};   // R
                8'h2C: pair = {makeKey(2, 4), KEY_NONE};   // T
                8'h16: pair = {makeKey(3, 0), KEY_NONE};   // 1
                8'h1E: pair = {makeKey(3, 1), KEY_NONE};   // 2
                8'h26: pair = {makeKey(3, 2), KEY_NONE};   // 3
                8'h25: pair = {makeKey(3, 3), KEY_NONE};   // 4
                8'h2E: pair = {makeKey(3, 4), KEY_NONE};   // 5
                8'h45: pair = {makeKey(4, 0), KEY_NONE};   // 0
                8'h46: pair = {makeKey(4, 1), KEY_NONE};   // 9
                8'h3E: pair = {makeKey(4, 2), KEY_NONE};   // 8
                8'h3D: pair = {makeKey(4, 3), KEY_NONE};   // 7
                8'h36: pair = {makeKey(4, 4), KEY_NONE};   // 6
                8'h4D: pair = {makeKey(5, 0), KEY_NONE};   // P
                8'h44: pair = {makeKey(5, 1), KEY_NONE};   // O
                8'h43: pair = {makeKey(5, 2), KEY_NONE};   // I
                8'h3C: pair = {makeKey(5, 3), KEY_NONE};   // U
                8'h35: pair = {makeKey(5, 4), KEY_NONE};   // Y
                8'h5A: pair = {makeKey(6, 0), KEY_NONE};   // ENTER
                8'h4B: pair = {makeKey(6, 1), KEY_NONE};   // L
                8'h42: pair = {makeKey(6, 2), KEY_NONE};   // K
                8'h3B: pair = {makeKey(6, 3), KEY_NONE};   // J
                8'h33: pair = {makeKey(6, 4), KEY_NONE};   // H
                8'h29: pair = {makeKey(7, 0), KEY_NONE};   // SPACE
                8'h11: pair = {SYM_KEY, KEY_NONE};         // Alt
                8'h3A: pair = {makeKey(7, 2), KEY_NONE};   // M
                8'h31: pair = {makeKey(7, 3), KEY_NONE};   // N
                8'h32: pair = {makeKey(7, 4), KEY_NONE};   // B
                8'h66: pair = {CAPS_KEY, makeKey(4, 0)};   // BACKSPACE is DELETE
                8'h76: pair = {CAPS_KEY, makeKey(7, 0)};   // ESC is BREAK
                // Punctuation keys follow the local shift
                8'h4E: pair = {SYM_KEY, shifted ? makeKey(4, 0) : makeKey(6, 3)};  // _ -
                8'h55: pair = {SYM_KEY, shifted ? makeKey(6, 2) : makeKey(6, 1)};  // + =
                8'h52: pair = {SYM_KEY, shifted ? makeKey(5, 0) : makeKey(4, 3)};  // " '
                8'h4C: pair = {SYM_KEY, shifted ? makeKey(0, 1) : makeKey(5, 1)};  // : ;
                8'h41: pair = {SYM_KEY, shifted ? makeKey(2, 3) : makeKey(7, 3)};  // < ,
                8'h49: pair = {SYM_KEY, shifted ? makeKey(2, 4) : makeKey(7, 2)};  // > .
                8'h4A: pair = {SYM_KEY, shifted ? makeKey(0, 3) : makeKey(0, 4)};  // ? /
                default: ;
            endcase
        end
    end

    // ==============================
    // Prefix and shift state
    // ==============================
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            extended <= 1'b0;
            released <= 1'b0;
            shifted  <= 1'b0;
            keyValid <= 1'b0;
        end else begin
            keyValid <= 1'b0;
            if (scanError) begin
                extended <= 1'b0;             // Broken sequence drops the prefixes
                released <= 1'b0;
            end else if (scanValid) begin
                if (scanCode == SC_EXTEND) begin
                    extended <= 1'b1;
                end else if (scanCode == SC_RELEASE) begin
                    released <= 1'b1;
                end else begin
                    extended <= 1'b0;
                    released <= 1'b0;
                    if (isShift)
                        shifted <= !released;
                    keyValid <= pair[1].valid;    // Unmapped codes stay silent
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scanValid) begin
            keyA  <= pair[1];
            keyB  <= pair[0];
            keyUp <= released;
        end
    end

    // Error branch has priority and would swallow a good code
    assert property (@(posedge clk) disable iff (!nreset) !(scanValid && scanError));

endmodule

`default_nettype wire

//--- keyMatrix.sv
// Active-low 8x5 key state; one action per cycle, keyA and keyB never name the same key
`timescale 1ns/1ps
`default_nettype none

module keyMatrix
    import zxKeyPkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   nreset,
    input  wire logic                   keyValid,
    input  wire keyIdx                  keyA,
    input  wire keyIdx                  keyB,
    input  wire logic                   keyUp,
    output logic [ROWS*COLS-1:0]        keyRows   // Row r at bits r*COLS +: COLS
);

    logic [ROWS-1:0][COLS-1:0] keys;          // 0 means held down

    // ==============================
    // Key state update
    // ==============================
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            keys <= '1;                       // Nothing pressed
        end else if (keyValid) begin
            keys[keyA.row][keyA.col] <= keyUp;
            if (keyB.valid)
                keys[keyB.row][keyB.col] <= keyUp;  // Composite key
        end
    end

    assign keyRows = keys;

    // Decoder table only produces columns 0..4
    assert property (@(posedge clk) disable iff (!nreset)
        keyValid |-> (keyA.col < COLS));

endmodule

`default_nettype wire

//--- rowReader.sv
// Combinational port read; several low address bits AND their rows as on the real ULA
`timescale 1ns/1ps
`default_nettype none

module rowReader
    import zxKeyPkg::*;
(
    input  wire logic [7:0]             addrHigh,  // A15..A8, low selects a row
    input  wire logic [ROWS*COLS-1:0]   keyRows,
    output logic      [COLS-1:0]        keyRow,    // Active low keys
    output logic                        pressed    // Any key down
);

    // ==============================
    // Row select and merge
    // ==============================
    always_comb begin
        keyRow = '1;                          // No row selected reads 1F
        for (int r = 0; r < ROWS; r++) begin
            if (!addrHigh[r])
                keyRow = keyRow & keyRows[r*COLS +: COLS];
        end
    end

    assign pressed = ~&keyRows;               // Any zero anywhere

endmodule

`default_nettype wire

//--- zxKeyboardTop.sv
// PS/2 keyboard to Spectrum matrix; receive only, keyRow and pressed lag scanValid by 2 cycles
`timescale 1ns/1ps
`default_nettype none

module zxKeyboardTop
    import zxKeyPkg::*;
#(
    parameter int FILTER_LEN = 4              // PS/2 clock filter length
) (
    input  wire logic        clk,
    input  wire logic        nreset,
    input  wire logic        ps2Clk,
    input  wire logic        ps2Data,
    input  wire logic [15:0] addr,            // Z80 address bus
    output logic      [4:0]  keyRow,
    output logic             pressed,
    output logic             ps2Error         // Bad frame strobe
);

    logic [7:0]           scanCode;
    logic                 scanValid;
    logic                 scanError;
    logic                 keyValid;
    keyIdx                keyA;
    keyIdx                keyB;
    logic                 keyUp;
    logic [ROWS*COLS-1:0] keyRows;

    ps2Receiver #(
        .FILTER_LEN (FILTER_LEN)
    ) i_ps2Receiver (
        .clk       (clk),
        .nreset    (nreset),
        .ps2Clk    (ps2Clk),
        .ps2Data   (ps2Data),
        .scanCode  (scanCode),
        .scanValid (scanValid),
        .scanError (scanError)
    );

    scanDecoder i_scanDecoder (
        .clk       (clk),
        .nreset    (nreset),
        .scanCode  (scanCode),
        .scanValid (scanValid),
        .scanError (scanError),
        .keyValid  (keyValid),
        .keyA      (keyA),
        .keyB      (keyB),
        .keyUp     (keyUp)
    );

    keyMatrix i_keyMatrix (
        .clk      (clk),
        .nreset   (nreset),
        .keyValid (keyValid),
        .keyA     (keyA),
        .keyB     (keyB),
        .keyUp    (keyUp),
        .keyRows  (keyRows)
    );

    rowReader i_rowReader (
        .addrHigh (addr[15:8]),               // Row select lives in the high byte
        .keyRows  (keyRows),
        .keyRow   (keyRow),
        .pressed  (pressed)
    );

    assign ps2Error = scanError;

endmodule

`default_nettype wire

//--- tbChecker.sv
// Reference matrix fed from the raw PS/2 lines; only the codes driven by the testbench are mapped
`timescale 1ns/1ps
`default_nettype none

module tbChecker (
    input  wire logic        clk,
    input  wire logic        nreset,
    input  wire logic        ps2Clk,
    input  wire logic        ps2Data,
    input  wire logic [15:0] addr,
    input  wire logic [4:0]  keyRow,
    input  wire logic        pressed,
    input  wire logic        ps2Error,
    input  wire logic        checkEn,         // High while addr is swept
    output int               errors,
    output int               checks
);

    localparam logic [5:0] NK = 6'h3F;        // No key in a map slot

    logic [39:0] refKeys = '1;                // Active low, row r at r*5
    logic [10:0] frameBits = '0;
    int          bitCount = 0;
    logic        ext = 1'b0;                  // E0 seen
    logic        rel = 1'b0;                  // F0 seen
    logic        sh = 1'b0;                   // Local shift held
    int          expErr = 0;                  // Bad frames sent
    int          seenErr = 0;                 // ps2Error pulses seen
    logic [4:0]  expRow;

    initial begin
        errors = 0;
        checks = 0;
    end

    // Bit index of a Spectrum key
    function automatic logic [5:0] pos(input int row, input int col);
        return 6'(row * 5 + col);
    endfunction

    // ==============================
    // Set 2 code to Spectrum keys
    // ==============================
    function automatic logic [11:0] mapCode(input logic [7:0] code, input logic ex,
                                            input logic shf);
        logic [11:0] m;
        m = {NK, NK};
        if (ex) begin
            case (code)
                8'h6B: m = {pos(0, 0), pos(3, 4)};    // Left, CAPS + 5
                8'h72: m = {pos(0, 0), pos(4, 4)};    // Down, CAPS + 6
                8'h75: m = {pos(0, 0), pos(4, 3)};    // Up, CAPS + 7
                8'h74: m = {pos(0, 0), pos(4, 2)};    // Right, CAPS + 8
                default: ;
            endcase
        end else begin
            case (code)
                8'h1C: m = {pos(1, 0), NK};           // A
                8'h32: m = {pos(7, 4), NK};           // B
                8'h21: m = {pos(0, 3), NK};           // C
                8'h16: m = {pos(3, 0), NK};           // 1
                8'h45: m = {pos(4, 0), NK};           // 0
                8'h3D: m = {pos(4, 3), NK};           // 7
                8'h29: m = {pos(7, 0), NK};           // SPACE
                8'h5A: m = {pos(6, 0), NK};           // ENTER
                8'h4D: m = {pos(5, 0), NK};           // P
                8'h33: m = {pos(6, 4), NK};           // H
                8'h15: m = {pos(2, 0), NK};           // Q
                8'h2A: m = {pos(0, 4), NK};           // V
                8'h14: m = {pos(0, 0), NK};           // Ctrl
                8'h11: m = {pos(7, 1), NK};           // Alt
                8'h66: m = {pos(0, 0), pos(4, 0)};    // BACKSPACE
                8'h76: m = {pos(0, 0), pos(7, 0)};    // ESC
                8'h4E: m = {pos(7, 1), shf ? pos(4, 0) : pos(6, 3)};  // _ -
                8'h55: m = {pos(7, 1), shf ? pos(6, 2) : pos(6, 1)};  // + =
                8'h4A: m = {pos(7, 1), shf ? pos(0, 3) : pos(0, 4)};  // ? /
                default: ;
            endcase
        end
        return m;
    endfunction

    task automatic applyCode(input logic [7:0] code);
        logic [11:0] m;
        if (code == 8'hE0) begin
            ext = 1'b1;
        end else if (code == 8'hF0) begin
            rel = 1'b1;
        end else begin
            if (!ext && (code == 8'h12 || code == 8'h59))
                sh = !rel;                    // Shift keys stay local
            m = mapCode(code, ext, sh);
            if (m[11:6] != NK)
                refKeys[m[11:6]] = rel;
            if (m[5:0] != NK)
                refKeys[m[5:0]] = rel;
            ext = 1'b0;
            rel = 1'b0;
        end
    endtask

    // ==============================
    // Frame decode from the raw lines
    // ==============================
    always @(negedge ps2Clk) begin
        frameBits = {ps2Data, frameBits[10:1]};   // LSB first
        bitCount++;
        if (bitCount == 11) begin
            bitCount = 0;
            if (!frameBits[0] && (^frameBits[9:1]) && frameBits[10]) begin
                applyCode(frameBits[8:1]);
            end else begin
                expErr++;                     // Bad frame drops prefixes
                ext = 1'b0;
                rel = 1'b0;
            end
        end
    end

    // Sampled on the falling clock, away from DUT updates
    always @(negedge clk) begin
        if (nreset && ps2Error)
            seenErr++;
        if (checkEn) begin
            expRow = 5'h1F;
            for (int r = 0; r < 8; r++) begin
                if (!addr[8 + r])
                    expRow = expRow & refKeys[r*5 +: 5];   // Rows merge like the ULA
            end
            checks++;
            if (keyRow !== expRow) begin
                errors++;
                $display("Mismatch keyRow addr %h: got %h, exp %h", addr, keyRow, expRow);
            end
            if (pressed !== ~&refKeys) begin
                errors++;
                $display("Mismatch pressed: got %h, exp %h", pressed, ~&refKeys);
            end
            if (ps2Error !== 1'b0) begin
                errors++;
                $display("Mismatch ps2Error while idle: got %h, exp 0", ps2Error);
            end
            if (seenErr != expErr) begin
                errors++;
                $display("Mismatch ps2Error pulse count: got %h, exp %h", seenErr, expErr);
                seenErr = expErr;             // Resync, report once
            end
        end
    end

endmodule

`default_nettype wire

//--- tbZxKeyboard.sv
// Drives PS/2 frames at 20 system cycles per bit into the top level; receive path only
`timescale 1ns/1ps
`default_nettype none

module tbZxKeyboard;

    localparam int HALF   = 10;               // PS/2 half period in clk cycles
    localparam int FRAMES = 130;              // 36 + 32 + 27 + 20 + 8 frames, rounded up
    localparam int LIMIT  = FRAMES * 250 + 1000;
    localparam logic [7:0] CODES [14] = '{8'h1C, 8'h32, 8'h21, 8'h16, 8'h45, 8'h3D, 8'h29,
                                          8'h5A, 8'h4D, 8'h33, 8'h15, 8'h2A, 8'h05, 8'h0E};
    localparam logic [7:0] COMBOS [8] = '{8'h14, 8'h11, 8'h66, 8'h76,
                                          8'h6B, 8'h72, 8'h75, 8'h74};  // Last 4 extended
    localparam logic [7:0] PUNCT [3]  = '{8'h4E, 8'h55, 8'h4A};

    logic        clk;
    logic        nreset;
    logic        ps2Clk;
    logic        ps2Data;
    logic [15:0] addr;
    logic [4:0]  keyRow;
    logic        pressed;
    logic        ps2Error;
    logic        checkEn;
    int          errors;
    int          checks;
    int          lastErrors = 0;
    int          lastChecks = 0;
    int          cycles = 0;
    logic [31:0] seed = 32'h98a796de;

    zxKeyboardTop #(.FILTER_LEN(4)) i_zxKeyboardTop (
        .clk(clk), .nreset(nreset), .ps2Clk(ps2Clk), .ps2Data(ps2Data), .addr(addr),
        .keyRow(keyRow), .pressed(pressed), .ps2Error(ps2Error)
    );

    tbChecker i_tbChecker (
        .clk(clk), .nreset(nreset), .ps2Clk(ps2Clk), .ps2Data(ps2Data), .addr(addr),
        .keyRow(keyRow), .pressed(pressed), .ps2Error(ps2Error), .checkEn(checkEn),
        .errors(errors), .checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;               // 25 MHz
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #2;                                   // Drive just after the edge
    endtask

    // ==============================
    // Address sweep and frames
    // ==============================
    task automatic sweepRows();
        logic [31:0] r;
        checkEn = 1'b1;
        for (int b = 0; b < 8; b++) begin
            addr = {~(8'h01 << b), 8'hFE};    // One row low
            waitCycles(1);
        end
        r = nextRand();
        addr = {r[23:16], 8'hFE};             // Usually several rows low
        waitCycles(1);
        checkEn = 1'b0;
        addr = 16'hFFFE;
    endtask

    task automatic sendFrame(input logic [7:0] code, input logic bad);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ bad, code, 1'b0};   // Stop, odd parity, data, start
        for (int i = 0; i < 11; i++) begin
            ps2Data = bits[i];
            waitCycles(HALF);
            ps2Clk = 1'b0;
            waitCycles(HALF);
            ps2Clk = 1'b1;
        end
        ps2Data = 1'b1;
        waitCycles(10);
        sweepRows();
    endtask

    task automatic keyEvent(input logic [7:0] code, input logic ext, input logic up,
                            input logic bad);
        if (ext)
            sendFrame(8'hE0, 1'b0);
        if (up)
            sendFrame(8'hF0, 1'b0);
        sendFrame(code, bad);
    endtask

    task automatic reportTest(input string name);
        $display("Test %-22s checks %0d  errors %0d", name, checks - lastChecks,
                 errors - lastErrors);
        lastChecks = checks;
        lastErrors = errors;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        logic [31:0] r;
        logic [7:0]  first;
        logic [7:0]  second;
        logic [7:0]  p;
        logic [7:0]  shiftCode;
        logic        bad;
        logic        lastBad;
        nreset = 1'b0;
        ps2Clk = 1'b1;
        ps2Data = 1'b1;
        addr = 16'hFFFE;
        checkEn = 1'b0;
        repeat (10) @(posedge clk);
        #2 nreset = 1'b1;
        waitCycles(5);
        sweepRows();
        reportTest("reset state");
        for (int i = 0; i < 6; i++) begin
            r = nextRand();
            first = CODES[r[31:16] % 14];
            r = nextRand();
            second = CODES[r[31:16] % 14];
            keyEvent(first, 1'b0, 1'b0, 1'b0);
            keyEvent(second, 1'b0, 1'b0, 1'b0);
            if (r[7]) begin                   // Release order
                keyEvent(first, 1'b0, 1'b1, 1'b0);
                keyEvent(second, 1'b0, 1'b1, 1'b0);
            end else begin
                keyEvent(second, 1'b0, 1'b1, 1'b0);
                keyEvent(first, 1'b0, 1'b1, 1'b0);
            end
        end
        reportTest("single keys");
        for (int i = 0; i < 8; i++) begin
            keyEvent(COMBOS[i], i >= 4, 1'b0, 1'b0);
            keyEvent(COMBOS[i], i >= 4, 1'b1, 1'b0);
        end
        reportTest("composite keys");
        for (int i = 0; i < 3; i++) begin
            r = nextRand();
            p = PUNCT[r[31:16] % 3];
            shiftCode = r[9] ? 8'h59 : 8'h12;
            keyEvent(p, 1'b0, 1'b0, 1'b0);    // Unshifted form
            keyEvent(p, 1'b0, 1'b1, 1'b0);
            keyEvent(shiftCode, 1'b0, 1'b0, 1'b0);
            keyEvent(p, 1'b0, 1'b0, 1'b0);    // Shifted form
            keyEvent(p, 1'b0, 1'b1, 1'b0);
            keyEvent(shiftCode, 1'b0, 1'b1, 1'b0);
        end
        reportTest("punctuation and shift");
        lastBad = 1'b0;
        for (int i = 0; i < 10; i++) begin
            r = nextRand();
            bad = (i == 0 || r[31]) && !lastBad;  // Good frame follows a bad one
            keyEvent(CODES[r[23:8] % 14], 1'b0, r[5], bad);
            lastBad = bad;
        end
        reportTest("corrupt parity");
        for (int i = 0; i < 8; i++) begin
            r = nextRand();
            keyEvent(CODES[r[31:16] % 14], 1'b0, 1'b0, 1'b0);
        end
        repeat (8) sweepRows();
        reportTest("multi-row reads");
        $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- zxKeyboardTop.f
zxKeyPkg.sv
ps2Receiver.sv
scanDecoder.sv
keyMatrix.sv
rowReader.sv
zxKeyboardTop.sv
tbChecker.sv
tbZxKeyboard.sv
